// File: source/sys_pkg.sv
// shared RV32IM decode types, packet structs and opcode constants for the decode stage
`default_nettype none

package sys_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes and fixed values
    //////////////////////////////////////////////////////////////////////

    // default superscalar width
    localparam int issue_width = 2;

    // x0, used when nothing is written back
    localparam logic [4:0] zero_reg = 5'd0;

    // base opcodes, RV32I
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct7 groups for OP / shift-immediate
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;
    localparam logic [6:0] f7_mext = 7'b0000001;

    // wait for interrupt, full word
    localparam logic [31:0] wfi_word = 32'h1050_0073;

    //////////////////////////////////////////////////////////////////////
    // instruction word views
    //////////////////////////////////////////////////////////////////////

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] off;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] et;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       of;
            logic [5:0] s;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] et;
            logic       f;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       of;
            logic [9:0] et;
            logic       s;
            logic [7:0] f;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_t;

    //////////////////////////////////////////////////////////////////////
    // decode enums and packets
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        fu_alu, fu_mult, fu_load, fu_store, fu_branch, fu_csr
    } fu_type_t;

    typedef enum logic [1:0] {
        opa_rs1, opa_pc, opa_zero
    } alu_opa_t;

    typedef enum logic [2:0] {
        opb_rs2, opb_i_imm, opb_s_imm, opb_b_imm, opb_u_imm, opb_j_imm
    } alu_opb_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_mul, alu_mulh, alu_mulhsu, alu_mulhu
    } alu_func_t;

    // one fetched slot
    typedef struct packed {
        inst_t       inst;
        logic [31:0] pc;
        logic [31:0] npc;
        logic        valid;
        logic        pred_taken;
    } inst_packet_t;

    // one decoded slot
    typedef struct packed {
        inst_t       inst;
        logic [31:0] pc;
        logic [31:0] npc;
        logic        valid;
        logic        pred_taken;
        logic [4:0]  reg1;
        logic [4:0]  reg2;
        logic [4:0]  dest_reg_idx;
        fu_type_t    fu_type;
        alu_opa_t    opa_select;
        alu_opb_t    opb_select;
        alu_func_t   alu_func;
        logic        mult;
        logic        rd_mem;
        logic        wr_mem;
        logic        cond_branch;
        logic        uncond_branch;
        logic        csr_op;
        logic        halt;
        logic        illegal;
    } decoded_packet_t;

endpackage

`default_nettype wire

// File: source/fetch_bus_if.sv
// bundle from the fetch-to-decode register into the decoder array, instantiated once in id_top
`timescale 1ns/1ps
`default_nettype none

interface fetch_bus_if
    import sys_pkg::*;
#(
    parameter int N = issue_width
);

    // latched fetch slots
    inst_packet_t [N-1:0] insts;

    // pipeline control, level stall and one-cycle flush
    logic stall;
    logic flush;

    // registered OR of the slot valid bits
    logic any_valid;

    // register side
    modport producer (output insts, output any_valid, input stall, input flush);

    // decode side
    modport consumer (input insts);

endinterface

`default_nettype wire

// File: source/decoder.sv
// combinational RV32IM control decode for one slot, instantiated per slot by decode
`timescale 1ns/1ps
`default_nettype none

module decoder
    import sys_pkg::*;
(
    input  inst_packet_t inst,
    output fu_type_t     fu_type,
    output alu_opa_t     opa_select,
    output alu_opb_t     opb_select,
    output alu_func_t    alu_func,
    output logic         has_dest,
    output logic         mult,
    output logic         rd_mem,
    output logic         wr_mem,
    output logic         cond_branch,
    output logic         uncond_branch,
    output logic         csr_op,
    output logic         halt,
    output logic         illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // field taps, r view covers all formats here
    assign opcode = inst.inst.r.opcode;
    assign funct3 = inst.inst.r.funct3;
    assign funct7 = inst.inst.r.funct7;

    always_comb begin
        // defaults, plain add with rs1/rs2 and no side effects
        fu_type       = fu_alu;
        opa_select    = opa_rs1;
        opb_select    = opb_rs2;
        alu_func      = alu_add;
        has_dest      = 1'b0;
        mult          = 1'b0;
        rd_mem        = 1'b0;
        wr_mem        = 1'b0;
        cond_branch   = 1'b0;
        uncond_branch = 1'b0;
        csr_op        = 1'b0;
        halt          = 1'b0;
        illegal       = 1'b0;

        if (inst.valid) begin
            case (opcode)
                op_lui: begin
                    has_dest   = 1'b1;
                    opa_select = opa_zero;
                    opb_select = opb_u_imm;
                end
                op_auipc: begin
                    has_dest   = 1'b1;
                    opa_select = opa_pc;
                    opb_select = opb_u_imm;
                end
                // link address written, target from pc + imm
                op_jal: begin
                    has_dest      = 1'b1;
                    fu_type       = fu_branch;
                    opa_select    = opa_pc;
                    opb_select    = opb_j_imm;
                    uncond_branch = 1'b1;
                end
                op_jalr: begin
                    has_dest      = 1'b1;
                    fu_type       = fu_branch;
                    opb_select    = opb_i_imm;
                    uncond_branch = 1'b1;
                    illegal       = (funct3 != 3'b000);
                end
                // funct3 010 and 011 unused
                op_branch: begin
                    fu_type     = fu_branch;
                    opa_select  = opa_pc;
                    opb_select  = opb_b_imm;
                    cond_branch = 1'b1;
                    illegal     = (funct3[2:1] == 2'b01);
                end
                // lb lh lw lbu lhu only
                op_load: begin
                    has_dest   = 1'b1;
                    fu_type    = fu_load;
                    opb_select = opb_i_imm;
                    rd_mem     = 1'b1;
                    illegal    = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
                end
                op_store: begin
                    fu_type    = fu_store;
                    opb_select = opb_s_imm;
                    wr_mem     = 1'b1;
                    illegal    = (funct3[2] || funct3 == 3'b011);
                end
                op_imm: begin
                    has_dest   = 1'b1;
                    opb_select = opb_i_imm;
                    case (funct3)
                        3'b000: alu_func = alu_add;
                        3'b010: alu_func = alu_slt;
                        3'b011: alu_func = alu_sltu;
                        3'b100: alu_func = alu_xor;
                        3'b110: alu_func = alu_or;
                        3'b111: alu_func = alu_and;
                        3'b001: begin
                            alu_func = alu_sll;
                            illegal  = (funct7 != f7_base);
                        end
                        default: begin
                            // shamt shifts, upper bits pick logical or arithmetic
                            alu_func = (funct7 == f7_alt) ? alu_sra : alu_srl;
                            illegal  = (funct7 != f7_base) && (funct7 != f7_alt);
                        end
                    endcase
                end
                op_reg: begin
                    has_dest = 1'b1;
                    case (funct7)
                        f7_base: begin
                            case (funct3)
                                3'b000:  alu_func = alu_add;
                                3'b001:  alu_func = alu_sll;
                                3'b010:  alu_func = alu_slt;
                                3'b011:  alu_func = alu_sltu;
                                3'b100:  alu_func = alu_xor;
                                3'b101:  alu_func = alu_srl;
                                3'b110:  alu_func = alu_or;
                                default: alu_func = alu_and;
                            endcase
                        end
                        f7_alt: begin
                            alu_func = (funct3 == 3'b101) ? alu_sra : alu_sub;
                            illegal  = (funct3 != 3'b000) && (funct3 != 3'b101);
                        end
                        f7_mext: begin
                            mult    = 1'b1;
                            fu_type = fu_mult;
                            // no divider behind this stage, div and rem trap
                            illegal = funct3[2];
                            case (funct3[1:0])
                                2'b00:   alu_func = alu_mul;
                                2'b01:   alu_func = alu_mulh;
                                2'b10:   alu_func = alu_mulhsu;
                                default: alu_func = alu_mulhu;
                            endcase
                        end
                        default: illegal = 1'b1;
                    endcase
                end
                op_system: begin
                    fu_type = fu_csr;
                    if (inst.inst.raw == wfi_word) begin
                        halt = 1'b1;
                    end else if (funct3 != 3'b000 && funct3 != 3'b100) begin
                        // csrrw/s/c and immediate forms, old value goes to rd
                        csr_op   = 1'b1;
                        has_dest = 1'b1;
                    end else begin
                        illegal = 1'b1;
                    end
                end
                default: illegal = 1'b1;
            endcase
        end

        // trapped encodings carry no side effects
        if (illegal) begin
            fu_type       = fu_alu;
            opa_select    = opa_rs1;
            opb_select    = opb_rs2;
            alu_func      = alu_add;
            has_dest      = 1'b0;
            mult          = 1'b0;
            rd_mem        = 1'b0;
            wr_mem        = 1'b0;
            cond_branch   = 1'b0;
            uncond_branch = 1'b0;
            csr_op        = 1'b0;
            halt          = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/decode.sv
// N-wide decode stage, copies packet fields and runs one decoder per latched slot
`timescale 1ns/1ps
`default_nettype none

module decode
    import sys_pkg::*;
#(
    parameter int N = issue_width
)(
    fetch_bus_if.consumer          bus,
    output decoded_packet_t [N-1:0] id_packet
);

    for (genvar i = 0; i < N; i++) begin : g_slot
        fu_type_t  fu_type;
        alu_opa_t  opa_select;
        alu_opb_t  opb_select;
        alu_func_t alu_func;
        logic      has_dest, mult, rd_mem, wr_mem;
        logic      cond_branch, uncond_branch, csr_op, halt, illegal;

        decoder u_decoder (
            .inst          (bus.insts[i]),
            .fu_type       (fu_type),
            .opa_select    (opa_select),
            .opb_select    (opb_select),
            .alu_func      (alu_func),
            .has_dest      (has_dest),
            .mult          (mult),
            .rd_mem        (rd_mem),
            .wr_mem        (wr_mem),
            .cond_branch   (cond_branch),
            .uncond_branch (uncond_branch),
            .csr_op        (csr_op),
            .halt          (halt),
            .illegal       (illegal)
        );

        always_comb begin
            // pass-through fields
            id_packet[i].inst       = bus.insts[i].inst;
            id_packet[i].pc         = bus.insts[i].pc;
            id_packet[i].npc        = bus.insts[i].npc;
            id_packet[i].valid      = bus.insts[i].valid;
            id_packet[i].pred_taken = bus.insts[i].pred_taken;
            // source indices taken raw, consumers ignore unused ones
            id_packet[i].reg1       = bus.insts[i].inst.r.rs1;
            id_packet[i].reg2       = bus.insts[i].inst.r.rs2;
            // x0 when nothing is written back
            id_packet[i].dest_reg_idx = has_dest ? bus.insts[i].inst.r.rd : zero_reg;
            // control from the slot decoder
            id_packet[i].fu_type       = fu_type;
            id_packet[i].opa_select    = opa_select;
            id_packet[i].opb_select    = opb_select;
            id_packet[i].alu_func      = alu_func;
            id_packet[i].mult          = mult;
            id_packet[i].rd_mem        = rd_mem;
            id_packet[i].wr_mem        = wr_mem;
            id_packet[i].cond_branch   = cond_branch;
            id_packet[i].uncond_branch = uncond_branch;
            id_packet[i].csr_op        = csr_op;
            id_packet[i].halt          = halt;
            id_packet[i].illegal       = illegal;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_id_reg.sv
// fetch-to-decode pipeline register, holds on stall and drops valid slots on flush or reset
`timescale 1ns/1ps
`default_nettype none

module fetch_id_reg
    import sys_pkg::*;
#(
    parameter int N = issue_width
)(
    input  logic                 clock,
    input  logic                 rst,
    input  inst_packet_t [N-1:0] d,
    fetch_bus_if.producer        bus
);

    logic d_any_valid;

    // any incoming slot live
    always_comb begin
        d_any_valid = 1'b0;
        for (int i = 0; i < N; i++) begin
            d_any_valid = d_any_valid | d[i].valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // slot register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst || bus.flush) begin
            // flush beats stall, payload fields left as they were
            for (int i = 0; i < N; i++) begin
                bus.insts[i].valid      <= 1'b0;
                bus.insts[i].pred_taken <= 1'b0;
            end
            bus.any_valid <= 1'b0;
        end else if (!bus.stall) begin
            bus.insts     <= d;
            bus.any_valid <= d_any_valid;
        end
        // stall alone, hold everything
    end

endmodule

`default_nettype wire

// File: source/id_top.sv
// decode stage top level, joins the fetch-to-decode register and the decoder array
`timescale 1ns/1ps
`default_nettype none

module id_top
    import sys_pkg::*;
#(
    parameter int N = issue_width
)(
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    flush,
    input  inst_packet_t    [N-1:0] in_insts,
    output decoded_packet_t [N-1:0] id_packet,
    output logic                    id_any_valid
);

    //////////////////////////////////////////////////////////////////////
    // register to decode bus
    //////////////////////////////////////////////////////////////////////

    fetch_bus_if #(
        .N (N)
    ) bus ();

    // pipeline control straight from the ports
    assign bus.stall    = stall;
    assign bus.flush    = flush;
    assign id_any_valid = bus.any_valid;

    //////////////////////////////////////////////////////////////////////
    // stages
    //////////////////////////////////////////////////////////////////////

    // one cycle, latches fetch slots
    fetch_id_reg #(
        .N (N)
    ) u_fetch_id_reg (
        .clock (clock),
        .rst   (rst),
        .d     (in_insts),
        .bus   (bus.producer)
    );

    // zero cycles, decode off the register
    decode #(
        .N (N)
    ) u_decode (
        .bus       (bus.consumer),
        .id_packet (id_packet)
    );

endmodule

`default_nettype wire

// File: sim/id_assertions.sv
// register rule checks, bound into each fetch_id_reg instance during simulation
`timescale 1ns/1ps
`default_nettype none

module id_assertions
    import sys_pkg::*;
#(
    parameter int N = issue_width
)(
    input logic                 clock,
    input logic                 rst,
    input logic                 stall,
    input logic                 flush,
    input logic                 any_valid,
    input inst_packet_t [N-1:0] insts
);

    logic [N-1:0] valid_bits;

    // per-slot valid bits gathered into one vector
    always_comb begin
        for (int i = 0; i < N; i++) begin
            valid_bits[i] = insts[i].valid;
        end
    end

    // flush drops every slot, stall or not
    a_flush_clears: assert property (@(posedge clock) flush |=> (valid_bits == '0))
        else $error("flush left a slot valid");

    // plain stall keeps the whole register
    a_stall_holds: assert property (@(posedge clock) (stall && !flush && !rst) |=> $stable(insts))
        else $error("register contents moved during stall");

    a_reset_idle: assert property (@(posedge clock) rst |=> !any_valid)
        else $error("any_valid high after reset");

endmodule

bind fetch_id_reg id_assertions #(
    .N (N)
) u_id_assertions (
    .clock     (clock),
    .rst       (rst),
    .stall     (bus.stall),
    .flush     (bus.flush),
    .any_valid (bus.any_valid),
    .insts     (bus.insts)
);

`default_nettype wire

// File: sim/id_tb.sv
// self-checking testbench for id_top driving random RV32IM slots with stall, flush and reset
`timescale 1ns/1ps
`default_nettype none

module id_tb
    import sys_pkg::*;
;

    localparam int N              = issue_width;
    localparam int reset_cycles   = 8;
    localparam int rand_cycles    = 400;
    localparam int tail_cycles    = 12;
    localparam int timeout_cycles = 2 * (rand_cycles + tail_cycles) + reset_cycles;

    logic                    clock;
    logic                    rst;
    logic                    stall;
    logic                    flush;
    inst_packet_t    [N-1:0] in_insts;
    decoded_packet_t [N-1:0] id_packet;
    logic                    id_any_valid;

    // model of the register and queued predictions
    inst_packet_t    [N-1:0] held;
    logic                    held_any;
    decoded_packet_t [N-1:0] pred;
    decoded_packet_t [N-1:0] exp_q[$];
    logic                    any_q[$];
    decoded_packet_t [N-1:0] exp_now;
    logic                    any_now;
    int                      err_count = 0;
    int                      cycle_count = 0;

    id_top #(
        .N (N)
    ) dut_i (
        .clock        (clock),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .in_insts     (in_insts),
        .id_packet    (id_packet),
        .id_any_valid (id_any_valid)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // reference decode
    //////////////////////////////////////////////////////////////////////

    // encodings this stage accepts
    // div and rem trap
    function automatic bit legal(logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            op_lui, op_auipc, op_jal: return 1'b1;
            op_jalr:   return f3 == 3'd0;
            op_branch: return f3 != 3'd2 && f3 != 3'd3;
            op_load:   return f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            op_store:  return f3 <= 3'd2;
            op_imm: begin
                if (f3 == 3'd1)
                    return f7 == f7_base;
                if (f3 == 3'd5)
                    return f7 == f7_base || f7 == f7_alt;
                return 1'b1;
            end
            op_reg: begin
                if (f7 == f7_base)
                    return 1'b1;
                if (f7 == f7_alt)
                    return f3 == 3'd0 || f3 == 3'd5;
                return f7 == f7_mext && !f3[2];
            end
            op_system: return w == wfi_word || (f3 != 3'd0 && f3 != 3'd4);
            default:   return 1'b0;
        endcase
    endfunction

    // funct3 to ALU op
    // alt picks sub or sra
    function automatic alu_func_t base_func(logic [2:0] f3, logic alt);
        case (f3)
            3'd0:    return alt ? alu_sub : alu_add;
            3'd1:    return alu_sll;
            3'd2:    return alu_slt;
            3'd3:    return alu_sltu;
            3'd4:    return alu_xor;
            3'd5:    return alt ? alu_sra : alu_srl;
            3'd6:    return alu_or;
            default: return alu_and;
        endcase
    endfunction

    function automatic decoded_packet_t decode_ref(inst_packet_t p);
        decoded_packet_t e;
        logic [31:0]     w;
        logic [2:0]      f3;
        logic            wr;
        logic            ok;
        w  = p.inst.raw;
        f3 = w[14:12];
        wr = 1'b0;
        ok = 1'b0;
        e  = '0;
        e.inst       = p.inst;
        e.pc         = p.pc;
        e.npc        = p.npc;
        e.valid      = p.valid;
        e.pred_taken = p.pred_taken;
        e.reg1       = w[19:15];
        e.reg2       = w[24:20];
        if (p.valid)
            ok = legal(w);
        if (ok) begin
            case (w[6:0])
                op_lui: begin
                    wr = 1'b1;
                    e.opa_select = opa_zero;
                    e.opb_select = opb_u_imm;
                end
                op_auipc: begin
                    wr = 1'b1;
                    e.opa_select = opa_pc;
                    e.opb_select = opb_u_imm;
                end
                op_jal: begin
                    wr = 1'b1;
                    e.fu_type       = fu_branch;
                    e.opa_select    = opa_pc;
                    e.opb_select    = opb_j_imm;
                    e.uncond_branch = 1'b1;
                end
                op_jalr: begin
                    wr = 1'b1;
                    e.fu_type       = fu_branch;
                    e.opb_select    = opb_i_imm;
                    e.uncond_branch = 1'b1;
                end
                op_branch: begin
                    e.fu_type     = fu_branch;
                    e.opa_select  = opa_pc;
                    e.opb_select  = opb_b_imm;
                    e.cond_branch = 1'b1;
                end
                op_load: begin
                    wr = 1'b1;
                    e.fu_type    = fu_load;
                    e.opb_select = opb_i_imm;
                    e.rd_mem     = 1'b1;
                end
                op_store: begin
                    e.fu_type    = fu_store;
                    e.opb_select = opb_s_imm;
                    e.wr_mem     = 1'b1;
                end
                op_imm: begin
                    wr = 1'b1;
                    e.opb_select = opb_i_imm;
                    e.alu_func   = base_func(f3, f3 == 3'd5 && w[31:25] == f7_alt);
                end
                op_reg: begin
                    wr = 1'b1;
                    if (w[31:25] == f7_mext) begin
                        e.mult    = 1'b1;
                        e.fu_type = fu_mult;
                        case (f3[1:0])
                            2'd0:    e.alu_func = alu_mul;
                            2'd1:    e.alu_func = alu_mulh;
                            2'd2:    e.alu_func = alu_mulhsu;
                            default: e.alu_func = alu_mulhu;
                        endcase
                    end else begin
                        e.alu_func = base_func(f3, w[31:25] == f7_alt);
                    end
                end
                default: begin
                    // wfi halts and CSR ops write the old value
                    e.fu_type = fu_csr;
                    e.halt    = (w == wfi_word);
                    e.csr_op  = (w != wfi_word);
                    wr        = (w != wfi_word);
                end
            endcase
        end
        e.illegal      = p.valid && !ok;
        e.dest_reg_idx = wr ? w[11:7] : zero_reg;
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // weighted pick of legal forms
    // the last two entries leave the raw word
    function automatic logic [31:0] gen_inst();
        logic [31:0] w;
        logic [2:0]  f3;
        w  = $urandom;
        f3 = w[14:12];
        case ($urandom_range(0, 13))
            0: w[6:0] = op_lui;
            1: w[6:0] = op_auipc;
            2: w[6:0] = op_jal;
            3: begin
                w[6:0]   = op_jalr;
                w[14:12] = 3'd0;
            end
            4: begin
                w[6:0] = op_branch;
                w[14]  = w[14] | (f3[2:1] == 2'b01);
            end
            5: begin
                w[6:0]   = op_load;
                w[14:12] = (f3 == 3'd3 || f3 > 3'd5) ? 3'd2 : f3;
            end
            6: begin
                w[6:0]   = op_store;
                w[14:12] = (f3[1:0] == 2'b11) ? 3'd2 : {1'b0, f3[1:0]};
            end
            7: begin
                w[6:0] = op_imm;
                if (f3 == 3'd1)
                    w[31:25] = f7_base;
                if (f3 == 3'd5)
                    w[31:25] = w[31] ? f7_alt : f7_base;
            end
            8: begin
                w[6:0]   = op_reg;
                w[31:25] = f7_base;
            end
            9: begin
                w[6:0]   = op_reg;
                w[31:25] = f7_alt;
                w[14:12] = f3[0] ? 3'd5 : 3'd0;
            end
            10: begin
                w[6:0]   = op_reg;
                w[31:25] = f7_mext;
            end
            11: begin
                w[6:0] = op_system;
                if (f3 == 3'd7)
                    w = wfi_word;
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic drive_slots(input bit all_valid);
        for (int i = 0; i < N; i++) begin
            in_insts[i].inst.raw   = gen_inst();
            in_insts[i].pc         = $urandom & 32'hffff_fffc;
            in_insts[i].npc        = in_insts[i].pc + 32'd4;
            in_insts[i].valid      = all_valid || ($urandom_range(0, 3) != 0);
            in_insts[i].pred_taken = $urandom_range(0, 1);
        end
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "decode output mismatch");
        end
    endtask

    task automatic compare_slot(input int i, input decoded_packet_t got,
                                input decoded_packet_t exp);
        string s;
        s = $sformatf("id_packet[%0d].", i);
        check({s, "inst"}, got.inst.raw, exp.inst.raw);
        check({s, "pc"}, got.pc, exp.pc);
        check({s, "npc"}, got.npc, exp.npc);
        check({s, "valid"}, got.valid, exp.valid);
        check({s, "pred_taken"}, got.pred_taken, exp.pred_taken);
        check({s, "reg1"}, got.reg1, exp.reg1);
        check({s, "reg2"}, got.reg2, exp.reg2);
        check({s, "dest_reg_idx"}, got.dest_reg_idx, exp.dest_reg_idx);
        check({s, "fu_type"}, got.fu_type, exp.fu_type);
        check({s, "opa_select"}, got.opa_select, exp.opa_select);
        check({s, "opb_select"}, got.opb_select, exp.opb_select);
        check({s, "alu_func"}, got.alu_func, exp.alu_func);
        check({s, "mult"}, got.mult, exp.mult);
        check({s, "rd_mem"}, got.rd_mem, exp.rd_mem);
        check({s, "wr_mem"}, got.wr_mem, exp.wr_mem);
        check({s, "cond_branch"}, got.cond_branch, exp.cond_branch);
        check({s, "uncond_branch"}, got.uncond_branch, exp.uncond_branch);
        check({s, "csr_op"}, got.csr_op, exp.csr_op);
        check({s, "halt"}, got.halt, exp.halt);
        check({s, "illegal"}, got.illegal, exp.illegal);
    endtask

    //////////////////////////////////////////////////////////////////////
    // model, comparison and watchdog
    //////////////////////////////////////////////////////////////////////

    // register model stepping on the DUT edge
    always @(posedge clock) begin
        if (rst || flush) begin
            for (int i = 0; i < N; i++) begin
                held[i].valid      = 1'b0;
                held[i].pred_taken = 1'b0;
            end
            held_any = 1'b0;
        end else if (!stall) begin
            held     = in_insts;
            held_any = 1'b0;
            for (int i = 0; i < N; i++) begin
                held_any = held_any | in_insts[i].valid;
            end
        end
        for (int i = 0; i < N; i++) begin
            pred[i] = decode_ref(held[i]);
        end
        exp_q.push_back(pred);
        any_q.push_back(held_any);
    end

    // compare mid-cycle once decode has settled
    always @(negedge clock) begin
        if (exp_q.size() > 0) begin
            exp_now = exp_q.pop_front();
            any_now = any_q.pop_front();
            check("id_any_valid", id_any_valid, any_now);
            for (int i = 0; i < N; i++) begin
                compare_slot(i, id_packet[i], exp_now[i]);
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int stall_left;
        void'($urandom(32'h99ec435b));
        stall_left = 0;
        rst        = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        in_insts   = '0;
        repeat (reset_cycles) @(posedge clock);
        #1;
        rst = 1'b0;

        // mixed traffic with short stall runs and rare flushes
        for (int c = 0; c < rand_cycles; c++) begin
            drive_slots(c < 20);
            if (stall_left > 0) begin
                stall_left--;
                stall = 1'b1;
            end else if ($urandom_range(0, 9) == 0) begin
                stall_left = $urandom_range(2, 5);
                stall      = 1'b1;
            end else begin
                stall = 1'b0;
            end
            flush = ($urandom_range(0, 24) == 0);
            @(posedge clock);
            #1;
        end

        // load a full group, then hold it while inputs keep changing
        stall = 1'b0;
        flush = 1'b0;
        drive_slots(1'b1);
        @(posedge clock);
        #1;
        stall = 1'b1;
        repeat (4) begin
            drive_slots(1'b1);
            @(posedge clock);
            #1;
        end

        // flush while stalled
        flush = 1'b1;
        drive_slots(1'b1);
        @(posedge clock);
        #1;
        flush = 1'b0;
        stall = 1'b0;
        for (int i = 0; i < N; i++) begin
            in_insts[i].valid = 1'b0;
        end
        repeat (3) @(posedge clock);
        #3;

        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
source/sys_pkg.sv
source/fetch_bus_if.sv
source/decoder.sv
source/decode.sv
source/fetch_id_reg.sv
source/id_top.sv
sim/id_assertions.sv
sim/id_tb.sv
